//--- common/status_macros.svh
`ifndef STATUS_MACROS_SVH
`define STATUS_MACROS_SVH

// address byte that leads every status packet
`define STATUS_REG_ADDR 8'd7

// width of the parallel status word
`define STATUS_BITS 15

// payload bytes after the address byte
// (15 status bits + 6 seq bits + 3 pad bits = 3 bytes)
`define STATUS_PKT_BYTES 3

// 1 = status comes from another clock domain and gets one register stage
// 0 = status is already in this clock domain
`define STATUS_REGISTER_IN 1

`endif

//--- common/status_pkg.sv
`include "status_macros.svh"

package status_pkg;

    // command mode, taken from wd[7:6]
    typedef enum logic [1:0] {
        MODE_OFF       = 2'd0, // no status packets
        MODE_SINGLE    = 2'd1, // one packet per command write
        MODE_AUTO_KEEP = 2'd2, // packet on each change, seq fixed
        MODE_AUTO_INC  = 2'd3  // packet on each change, seq counts up
    } status_mode_e;

    // parallel status word as carried through the reporter
    typedef logic [`STATUS_BITS-1:0] status_word_t;

endpackage

//--- design/status_cmd.sv
`timescale 1ns/1ns

module status_cmd (
    input  logic                     rst,            // clock
    input  logic                     clk,            // async reset, active high
    input  logic                     we,             // command strobe
    input  logic [7:0]               wd,             // {mode, seq}
    input  logic                     start,          // address byte accepted
    input  logic                     status_changed, // from monitor
    output status_pkg::status_mode_e mode,
    output logic [5:0]               seq,
    output logic                     send_req        // packet wanted
);

    status_pkg::status_mode_e mode_w;   // mode field of the incoming byte
    logic                     cmd_pend; // request from a command write
    logic                     auto_on;  // either automatic mode

    assign mode_w = status_pkg::status_mode_e'(wd[7:6]);

    assign auto_on = (mode == status_pkg::MODE_AUTO_KEEP) ||
                     (mode == status_pkg::MODE_AUTO_INC);

    // one decision for the serializer
    assign send_req = cmd_pend || (auto_on && status_changed);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mode <= status_pkg::MODE_OFF;
        end else if (we) begin
            mode <= mode_w;
        end
    end

    // sequence number, reloaded by a write, counts per packet in auto-inc
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            seq <= 6'd0;
        end else if (we) begin
            seq <= wd[5:0];
        end else if ((mode == status_pkg::MODE_AUTO_INC) && start) begin
            seq <= seq + 6'd1; // wraps at 64
        end
    end

    // any write except off asks for one packet right away
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cmd_pend <= 1'b0;
        end else if (we && (mode_w != status_pkg::MODE_OFF)) begin
            cmd_pend <= 1'b1;
        end else if (start) begin
            cmd_pend <= 1'b0; // served by the packet now starting
        end
    end

endmodule

//--- design/status_gen.sv
`timescale 1ns/1ns

module status_gen (
    input  logic                     rst,    // clock
    input  logic                     clk,    // async active-high reset
    input  logic                     we,     // command strobe
    input  logic [7:0]               wd,     // command byte {mode, seq}
    input  status_pkg::status_word_t status, // parallel status from any clock domain
    output logic [7:0]               ad,     // byte-wide address/data
    output logic                     rq,     // request that is low on the last byte
    input  logic                     start   // address byte accepted
);

    logic [5:0]               seq;            // sequence number for next packet
    logic                     send_req;       // cmd -> serializer
    status_pkg::status_word_t status_cur;     // monitor -> serializer
    logic                     status_changed; // monitor -> cmd

    status_cmd status_cmd_i (
        .rst            (rst),
        .clk            (clk),
        .we             (we),
        .wd             (wd),
        .start          (start),
        .status_changed (status_changed),
        .mode           (),
        .seq            (seq),
        .send_req       (send_req)
    );

    status_monitor status_monitor_i (
        .rst            (rst),
        .clk            (clk),
        .start          (start),
        .status         (status),
        .status_cur     (status_cur),
        .status_changed (status_changed)
    );

    status_serializer status_serializer_i (
        .rst        (rst),
        .clk        (clk),
        .start      (start),
        .send_req   (send_req),
        .seq        (seq),
        .status_cur (status_cur),
        .ad         (ad),
        .rq         (rq)
    );

endmodule

//--- design/status_monitor.sv
`timescale 1ns/1ns

`include "status_macros.svh"

module status_monitor #(
    parameter bit register_in = `STATUS_REGISTER_IN // 1: one sync stage on status
) (
    input  logic                     rst,            // clock
    input  logic                     clk,            // async reset, active high
    input  logic                     start,          // packet starts, freeze status
    input  status_pkg::status_word_t status,         // raw status, maybe foreign domain
    output status_pkg::status_word_t status_cur,     // status in this domain
    output logic                     status_changed  // sticky, differs from last sent
);

    status_pkg::status_word_t status_frozen; // value sent with the last packet

    generate
        if (register_in) begin : g_status_reg
            status_pkg::status_word_t status_q;

            always_ff @(posedge rst or posedge clk) begin
                if (clk) begin
                    status_q <= '0;
                end else begin
                    status_q <= status;
                end
            end

            assign status_cur = status_q; // one cycle late
        end else begin : g_status_direct
            assign status_cur = status;
        end
    endgenerate

    // snapshot of what goes out in the packet
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_frozen <= '0;
        end else if (start) begin
            status_frozen <= status_cur;
        end
    end

    // stays set if status goes back to the old value,
    // only a new packet clears it
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_changed <= 1'b0;
        end else if (start) begin
            status_changed <= 1'b0;
        end else begin
            status_changed <= status_changed || (status_frozen != status_cur);
        end
    end

endmodule

//--- design/status_serializer.sv
`timescale 1ns/1ns

`include "status_macros.svh"

module status_serializer (
    input  logic                     rst,        // clock
    input  logic                     clk,        // async reset, active high
    input  logic                     start,      // address byte accepted downstream
    input  logic                     send_req,   // packet wanted
    input  logic [5:0]               seq,        // sequence number for byte 0
    input  status_pkg::status_word_t status_cur, // status to send
    output logic [7:0]               ad,         // byte-wide address/data
    output logic                     rq          // low on the last byte
);

    localparam int PKT_BITS = `STATUS_PKT_BYTES * 8;        // payload bits after address
    localparam int PAD_BITS = PKT_BITS - 6 - `STATUS_BITS; // zeros above the status

    logic [`STATUS_PKT_BYTES-1:0] rq_sr;   // request shift register, rq is bit 0
    logic [PKT_BITS-1:0]          data_sr; // byte 0 in the low bits
    logic [PKT_BITS-1:0]          payload; // packet as loaded on start
    logic                         snd_rest; // past the address, bytes still to go

    // byte 0: seq over status[1:0]
    // byte 1: status[9:2]
    // byte 2: pad over status[14:10]
    assign payload = {{PAD_BITS{1'b0}},
                      status_cur[`STATUS_BITS-1:2],
                      seq,
                      status_cur[1:0]};

    assign ad = data_sr[7:0];
    assign rq = rq_sr[0];

    // top bit low means start came, bit 0 high means not the last byte yet
    assign snd_rest = rq_sr[0] && !rq_sr[`STATUS_PKT_BYTES-1];

    // all ones while waiting for start, then drains one bit per byte
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rq_sr <= '0;
        end else if (send_req && !rq_sr[0]) begin
            rq_sr <= '1; // only when idle, one packet at a time
        end else if (start || !rq_sr[`STATUS_PKT_BYTES-1]) begin
            rq_sr <= rq_sr >> 1;
        end
    end

    // address at rest and while waiting, payload bytes after start
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            data_sr <= {{(PKT_BITS-8){1'b0}}, `STATUS_REG_ADDR};
        end else if (start) begin
            data_sr <= payload; // seq and status as they are now
        end else if (snd_rest) begin
            data_sr <= data_sr >> 8;
        end else begin
            data_sr <= {{(PKT_BITS-8){1'b0}}, `STATUS_REG_ADDR};
        end
    end

endmodule

//--- sources.f
+incdir+common
common/status_pkg.sv
design/status_cmd.sv
design/status_monitor.sv
design/status_serializer.sv
design/status_gen.sv
verif/tb_clock.sv
verif/status_gen_assertions.sv
verif/status_gen_tb.sv

//--- verif/status_gen_assertions.sv
`timescale 1ns/1ns

`include "status_macros.svh"

module status_gen_assertions (
    input logic                     rst,    // clock
    input logic                     clk,    // async reset, active high
    input logic                     we,     // command strobe
    input logic [7:0]               wd,     // command byte
    input status_pkg::status_word_t status, // raw status into the DUT
    input logic [7:0]               ad,     // address/data bus
    input logic                     rq,     // request
    input logic                     start   // address accepted
);

    int                       fail_count = 0; // read by the testbench at the end
    status_pkg::status_mode_e exp_mode;       // shadow of the mode register
    logic [5:0]               exp_seq;        // shadow of the sequence number
    logic                     exp_pend;       // shadow of the command request
    status_pkg::status_word_t status_d;       // status after the sync stage
    status_pkg::status_word_t status_used;    // status as the DUT sees it
    logic [1:0]               phase;          // 0 address, 1..3 payload byte on ad
    logic [7:0]               exp_b0;         // expected payload bytes
    logic [7:0]               exp_b1;
    logic [7:0]               exp_b2;
    logic                     inc_chain;      // last packet went out in auto-inc
    logic                     chk_inc;        // this packet must be last seq + 1
    logic [5:0]               last_seq;       // seq seen in the previous byte 0
    logic [5:0]               prev_seq;       // last_seq frozen at start
    logic [5:0]               exp_inc;        // wraps at 64

    assign status_used = `STATUS_REGISTER_IN ? status_d : status;
    assign exp_inc     = prev_seq + 6'd1;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_d <= '0;
        end else begin
            status_d <= status; // one cycle of delay like the sync stage
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            exp_mode  <= status_pkg::MODE_OFF;
            exp_seq   <= 6'd0;
            exp_pend  <= 1'b0;
            phase     <= 2'd0;
            exp_b0    <= 8'd0;
            exp_b1    <= 8'd0;
            exp_b2    <= 8'd0;
            inc_chain <= 1'b0;
            chk_inc   <= 1'b0;
            last_seq  <= 6'd0;
            prev_seq  <= 6'd0;
        end else begin
            if (we) begin
                exp_mode  <= status_pkg::status_mode_e'(wd[7:6]);
                exp_seq   <= wd[5:0];
                inc_chain <= 1'b0; // a write restarts the count
                if (wd[7:6] != 2'd0) begin
                    exp_pend <= 1'b1;
                end
            end else if (start) begin
                exp_pend  <= 1'b0;
                inc_chain <= (exp_mode == status_pkg::MODE_AUTO_INC);
                if (exp_mode == status_pkg::MODE_AUTO_INC) begin
                    exp_seq <= exp_seq + 6'd1;
                end
            end
            if (start) begin
                exp_b0   <= {exp_seq, status_used[1:0]};
                exp_b1   <= status_used[9:2];
                exp_b2   <= {3'b000, status_used[14:10]};
                chk_inc  <= inc_chain && (exp_mode == status_pkg::MODE_AUTO_INC);
                prev_seq <= last_seq;
                phase    <= 2'd1;
            end else if (phase != 2'd0) begin
                phase <= phase + 2'd1; // 3 wraps back to the address
            end
            if (phase == 2'd1) begin
                last_seq <= ad[7:2]; // seq field of the byte 0 just seen
            end
        end
    end

    a_addr_idle: assert property (@(posedge rst) disable iff (clk)
        phase == 2'd0 |-> ad == `STATUS_REG_ADDR)
        else begin
            $error("FAILED t=%0t ad expected %02h actual %02h",
                   $time, `STATUS_REG_ADDR, $sampled(ad));
            fail_count++;
        end

    // back-pressure, no limit on the wait
    a_wait_hold: assert property (@(posedge rst) disable iff (clk)
        rq && phase == 2'd0 |=> rq)
        else begin
            $error("FAILED t=%0t rq expected 1 actual %0b", $time, $sampled(rq));
            fail_count++;
        end

    a_start_req: assert property (@(posedge rst) disable iff (clk)
        start |-> rq && phase == 2'd0)
        else begin
            $error("FAILED t=%0t start came while no address byte was offered", $time);
            fail_count++;
        end

    a_tail_rq: assert property (@(posedge rst) disable iff (clk)
        phase != 2'd0 |-> rq == (phase != 2'd3))
        else begin
            $error("FAILED t=%0t rq expected %0b actual %0b",
                   $time, $sampled(phase) != 2'd3, $sampled(rq));
            fail_count++;
        end

    a_byte0: assert property (@(posedge rst) disable iff (clk)
        phase == 2'd1 |-> ad == exp_b0)
        else begin
            $error("FAILED t=%0t ad expected %02h actual %02h",
                   $time, $sampled(exp_b0), $sampled(ad));
            fail_count++;
        end

    a_byte1: assert property (@(posedge rst) disable iff (clk)
        phase == 2'd2 |-> ad == exp_b1)
        else begin
            $error("FAILED t=%0t ad expected %02h actual %02h",
                   $time, $sampled(exp_b1), $sampled(ad));
            fail_count++;
        end

    a_byte2: assert property (@(posedge rst) disable iff (clk)
        phase == 2'd3 |-> ad == exp_b2)
        else begin
            $error("FAILED t=%0t ad expected %02h actual %02h",
                   $time, $sampled(exp_b2), $sampled(ad));
            fail_count++;
        end

    a_seq_inc: assert property (@(posedge rst) disable iff (clk)
        phase == 2'd1 && chk_inc |-> ad[7:2] == exp_inc)
        else begin
            $error("FAILED t=%0t ad[7:2] expected %02h actual %02h",
                   $time, $sampled(exp_inc), $sampled(ad[7:2]));
            fail_count++;
        end

    // a command write gets its request out within two edges
    a_pend_rq: assert property (@(posedge rst) disable iff (clk)
        exp_pend && !rq && phase == 2'd0 |=> rq)
        else begin
            $error("FAILED t=%0t rq expected 1 actual %0b", $time, $sampled(rq));
            fail_count++;
        end

    // off and single never react to status changes
    a_quiet: assert property (@(posedge rst) disable iff (clk)
        (exp_mode == status_pkg::MODE_OFF || exp_mode == status_pkg::MODE_SINGLE)
        && !exp_pend && !rq && phase == 2'd0 |=> !rq)
        else begin
            $error("FAILED t=%0t rq expected 0 actual %0b", $time, $sampled(rq));
            fail_count++;
        end

endmodule

bind status_gen status_gen_assertions status_gen_assertions_i (
    .rst    (rst),
    .clk    (clk),
    .we     (we),
    .wd     (wd),
    .status (status),
    .ad     (ad),
    .rq     (rq),
    .start  (start)
);

//--- verif/status_gen_tb.sv
`timescale 1ns/1ns

module status_gen_tb;

    localparam int PHASE_CYCLES   = 300;                            // worst phase rounded up
    localparam int NUM_PHASES     = 6;
    localparam int TIMEOUT_CYCLES = PHASE_CYCLES * NUM_PHASES + 200; // 2000

    logic                     rst;              // clock
    logic                     clk;              // active-high reset
    logic                     we;
    logic [7:0]               wd;
    status_pkg::status_word_t status;
    logic [7:0]               ad;
    logic                     rq;
    logic                     start;
    int                       cycle_count = 0;
    int                       packet_count = 0; // packets taken by the responder
    int                       assert_errors;

    tb_clock #(.PERIOD(8)) tb_clock_i (.rst(rst));

    status_gen status_gen_i (
        .rst    (rst),
        .clk    (clk),
        .we     (we),
        .wd     (wd),
        .status (status),
        .ad     (ad),
        .rq     (rq),
        .start  (start)
    );

    always @(posedge rst) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic step(input int n);
        repeat (n) @(negedge rst);
    endtask

    task automatic write_cmd(input status_pkg::status_mode_e mode, input logic [5:0] seq);
        we = 1'b1;
        wd = {mode, seq};
        @(negedge rst);
        we = 1'b0; // one-cycle strobe
    endtask

    task automatic change_status();
        status_pkg::status_word_t flip;
        flip   = status_pkg::status_word_t'($urandom_range(32767, 1)); // never zero
        status = status ^ flip;
        @(negedge rst);
    endtask

    // accepts the address after a random delay and lets the packet drain
    task automatic serve_packet(input int max_wait);
        int delay;
        while (!rq) @(negedge rst);
        delay = $urandom_range(max_wait, 0);
        repeat (delay) @(negedge rst);
        start = 1'b1;
        @(negedge rst);
        start = 1'b0;
        while (rq) @(negedge rst); // rq drops on the last byte
        @(negedge rst);            // address back on ad
        packet_count++;
    endtask

    task automatic idle_without_packets();
        step(10);
        repeat (8) begin
            change_status(); // nothing may go out in mode off
            step(3);
        end
    endtask

    task automatic single_requests();
        repeat (3) begin
            status = status_pkg::status_word_t'($urandom());
            step(2);
            write_cmd(status_pkg::MODE_SINGLE, 6'($urandom_range(63, 0)));
            serve_packet(7);
            repeat (4) begin
                change_status(); // no packet expected
                step(4);
            end
        end
    endtask

    task automatic fixed_seq_auto();
        write_cmd(status_pkg::MODE_AUTO_KEEP, 6'($urandom_range(63, 0)));
        serve_packet(7);
        repeat (6) begin
            change_status();
            serve_packet(7);
        end
    endtask

    task automatic counting_seq_auto();
        write_cmd(status_pkg::MODE_AUTO_INC, 6'd61); // wraps past 63 below
        serve_packet(7);
        repeat (6) begin
            change_status();
            serve_packet(7);
        end
    endtask

    task automatic long_backpressure();
        repeat (3) begin
            change_status();
            serve_packet(40); // long waits in auto-inc
        end
        write_cmd(status_pkg::MODE_SINGLE, 6'($urandom_range(63, 0)));
        serve_packet(80);
    endtask

    task automatic quiet_after_off();
        write_cmd(status_pkg::MODE_AUTO_KEEP, 6'($urandom_range(63, 0)));
        serve_packet(7);
        change_status();
        while (!rq) @(negedge rst);
        write_cmd(status_pkg::MODE_OFF, 6'd0); // packet already waiting
        serve_packet(7);
        repeat (8) begin
            change_status();
            step(5);
        end
        step(10);
    endtask

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: test did not finish within %0d cycles, %0d assertion failures",
                 TIMEOUT_CYCLES, status_gen_i.status_gen_assertions_i.fail_count);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h912f_383b));
        clk    = 1'b1;
        we     = 1'b0;
        wd     = 8'd0;
        status = '0;
        start  = 1'b0;
        repeat (5) @(posedge rst);
        @(negedge rst);
        clk = 1'b0;

        idle_without_packets();
        single_requests();
        fixed_seq_auto();
        counting_seq_auto();
        long_backpressure();
        quiet_after_off();

        assert_errors = status_gen_i.status_gen_assertions_i.fail_count;
        $display("closing: %0d assertion failures, %0d packets served, %0d cycles",
                 assert_errors, packet_count, cycle_count);
        if (assert_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8 // ns, full period
) (
    output logic rst // clock out
);

    initial begin
        rst = 1'b0; // first rising edge half a period in
        forever begin
            #(PERIOD / 2) rst = ~rst;
        end
    end

endmodule
